//--- hdl/lane_pkg.sv
////////////////////////////////////////////////////////////////////////////
// Vector lane definitions
// Opcodes, element width, vector lengths and instruction depth shared by
// the operand-bus control blocks
////////////////////////////////////////////////////////////////////////////

`default_nettype none

package lane_pkg;

  // Width of one element on the lane datapath
  localparam int unsigned ElenWidth = 64;
  typedef logic [ElenWidth-1:0] elen_t;

  // Longest vector handled by one instruction
  localparam int unsigned MaxElems = 64;
  // Element count, must be able to hold MaxElems itself
  typedef logic [$clog2(MaxElems+1)-1:0] vlen_t;

  // Instructions in flight, also the depth of the order queue
  localparam int unsigned NrVInsn = 8;

  //////////////////////////////////////////////////////////////////////////
  // Opcodes
  //////////////////////////////////////////////////////////////////////////

  // Both reduction ranges must stay contiguous
  typedef enum logic [3:0] {
    VADD,
    VMUL,
    VREDSUM,
    VWREDSUM,
    VFREDUSUM,
    VFWREDOSUM,
    VSLIDEUP,
    VSLIDEDOWN,
    VLXE,
    VSXE
  } ara_op_e;

endpackage : lane_pkg

`default_nettype wire

//--- hdl/opbus_pkg.sv
////////////////////////////////////////////////////////////////////////////
// Operand-bus definitions
// Route kinds of the order queue and the select codes of the bus mux
////////////////////////////////////////////////////////////////////////////

`default_nettype none

package opbus_pkg;

  // Who consumes or produces the bus for one instruction
  typedef enum logic [1:0] {
    ROUTE_SLDU    = 2'd0,
    ROUTE_ADDRGEN = 2'd1,
    ROUTE_ALU_RED = 2'd2,
    ROUTE_FPU_RED = 2'd3
  } route_e;

  // Data source driving the shared bus
  typedef enum logic [1:0] {
    SEL_OPQ = 2'd0,
    SEL_ALU = 2'd1,
    SEL_FPU = 2'd2
  } bus_sel_e;

  // Occupancy of the order queue, 0 to NrVInsn inclusive
  localparam int unsigned UsageWidth = $clog2(lane_pkg::NrVInsn) + 1;

endpackage : opbus_pkg

`default_nettype wire

//--- hdl/opbus_order_fifo.sv
////////////////////////////////////////////////////////////////////////////
// Operand-bus order queue
// Keeps route kind and element count of every steered instruction in
// issue order, with a synchronous flush
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module opbus_order_fifo (
  input  wire logic               clk_i,
  input  wire logic               arst_n_i,
  input  wire logic               flush_i,
  input  wire logic               push_i,
  input  opbus_pkg::route_e       route_i,
  input  lane_pkg::vlen_t         count_i,
  input  wire logic               pop_i,
  output opbus_pkg::route_e       route_o,
  output lane_pkg::vlen_t         count_o,
  output logic                    empty_o,
  output logic                    full_o
);

  import lane_pkg::*;
  import opbus_pkg::*;

  // Storage
  route_e route_mem [NrVInsn];
  vlen_t  count_mem [NrVInsn];

  logic [$clog2(NrVInsn)-1:0] wr_ptr_q;
  logic [$clog2(NrVInsn)-1:0] rd_ptr_q;
  logic [UsageWidth-1:0]      usage_q;

  logic push_en;
  logic pop_en;

  assign empty_o = (usage_q == '0);
  assign full_o  = (usage_q == UsageWidth'(NrVInsn));

  assign push_en = push_i & ~full_o;
  assign pop_en  = pop_i & ~empty_o;

  // Head entry is read straight from the array
  assign route_o = route_mem[rd_ptr_q];
  assign count_o = count_mem[rd_ptr_q];

  always_ff @(posedge clk_i) begin
    if (push_en) begin
      route_mem[wr_ptr_q] <= route_i;
      count_mem[wr_ptr_q] <= count_i;
    end
  end

  // Pointers and occupancy
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      usage_q  <= '0;
    end else if (flush_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      usage_q  <= '0;
    end else begin
      if (push_en) begin
        wr_ptr_q <= (wr_ptr_q == NrVInsn - 1) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop_en) begin
        rd_ptr_q <= (rd_ptr_q == NrVInsn - 1) ? '0 : rd_ptr_q + 1'b1;
      end
      case ({push_en, pop_en})
        2'b10:   usage_q <= usage_q + 1'b1;
        2'b01:   usage_q <= usage_q - 1'b1;
        default: usage_q <= usage_q;
      endcase
    end
  end

  //////////////////////////////////////////////////////////////////////////
  // Assertions
  //////////////////////////////////////////////////////////////////////////

  // The issue side must respect the NrVInsn bound
  a_no_push_full: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    !(push_i && full_o && !flush_i))
    else $error("order queue pushed while full");

  // Completion events only for a live head
  a_no_pop_empty: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    !(pop_i && empty_o && !flush_i))
    else $error("order queue popped while empty");

endmodule : opbus_order_fifo

`default_nettype wire

//--- hdl/opbus_elem_counter.sv
////////////////////////////////////////////////////////////////////////////
// Stream element counter
// Counts bus handshakes of the head stream instruction and flags the
// beat that completes it
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module opbus_elem_counter (
  input  wire logic       clk_i,
  input  wire logic       arst_n_i,
  input  wire logic       flush_i,
  input  wire logic       active_i,
  input  lane_pkg::vlen_t count_i,
  input  wire logic       beat_i,
  output logic            done_o
);

  import lane_pkg::*;

  // Elements already sent for the current head
  vlen_t cnt_q;
  vlen_t cnt_next;
  logic  beat_en;

  assign beat_en  = active_i & beat_i;
  assign cnt_next = cnt_q + 1'b1;

  // Last element goes out in this cycle
  assign done_o = beat_en & (cnt_next == count_i);

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      cnt_q <= '0;
    end else if (flush_i || done_o) begin
      // Ready for the next head
      cnt_q <= '0;
    end else if (beat_en) begin
      cnt_q <= cnt_next;
    end
  end

  // Count stays below the head length while streaming
  a_cnt_bound: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    active_i |-> (cnt_q < count_i))
    else $error("element count 0x%0h reached head length 0x%0h", cnt_q, count_i);

endmodule : opbus_elem_counter

`default_nettype wire

//--- hdl/opbus_steer_ctrl.sv
////////////////////////////////////////////////////////////////////////////
// Operand-bus steering controller
// Registers issued instructions, classifies them into the order queue and
// derives the bus select and the pop from the queue head
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module opbus_steer_ctrl (
  input  wire logic           clk_i,
  input  wire logic           arst_n_i,
  input  wire logic           flush_i,
  input  wire logic           issue_valid_i,
  input  lane_pkg::ara_op_e   issue_op_i,
  input  lane_pkg::vlen_t     issue_len_i,
  input  opbus_pkg::route_e   head_route_i,
  input  wire logic           head_empty_i,
  input  wire logic           stream_done_i,
  input  wire logic           alu_red_done_i,
  input  wire logic           fpu_red_done_i,
  output logic                push_o,
  output opbus_pkg::route_e   push_route_o,
  output lane_pkg::vlen_t     push_count_o,
  output logic                pop_o,
  output logic                stream_active_o,
  output opbus_pkg::bus_sel_e bus_sel_o
);

  import lane_pkg::*;
  import opbus_pkg::*;

  // Issue register, cuts the path from the sequencer
  logic    valid_q;
  ara_op_e op_q;
  vlen_t   len_q;
  logic    steered;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= issue_valid_i & ~flush_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (issue_valid_i) begin
      op_q  <= issue_op_i;
      len_q <= issue_len_i;
    end
  end

  // Only bus users enter the queue
  always_comb begin
    push_route_o = ROUTE_SLDU;
    steered      = 1'b0;
    case (op_q) inside
      VSLIDEUP, VSLIDEDOWN: begin
        push_route_o = ROUTE_SLDU;
        steered      = 1'b1;
      end
      VLXE, VSXE: begin
        push_route_o = ROUTE_ADDRGEN;
        steered      = 1'b1;
      end
      [VREDSUM:VWREDSUM]: begin
        push_route_o = ROUTE_ALU_RED;
        steered      = 1'b1;
      end
      [VFREDUSUM:VFWREDOSUM]: begin
        push_route_o = ROUTE_FPU_RED;
        steered      = 1'b1;
      end
      default: ;
    endcase
  end

  assign push_o       = valid_q & steered;
  assign push_count_o = len_q;

  // Head decides pop, select and stream activity
  always_comb begin
    pop_o           = 1'b0;
    stream_active_o = 1'b0;
    bus_sel_o       = SEL_OPQ;
    if (!head_empty_i) begin
      unique case (head_route_i)
        ROUTE_ALU_RED: begin
          pop_o     = alu_red_done_i;
          bus_sel_o = SEL_ALU;
        end
        ROUTE_FPU_RED: begin
          pop_o     = fpu_red_done_i;
          bus_sel_o = SEL_FPU;
        end
        default: begin
          pop_o           = stream_done_i;
          stream_active_o = 1'b1;
        end
      endcase
    end
  end

  // A reduction unit finishes only the reduction that owns the bus
  a_alu_done_head: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    alu_red_done_i |-> (!head_empty_i && head_route_i == ROUTE_ALU_RED))
    else $error("ALU reduction done while not at the head");

  a_fpu_done_head: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    fpu_red_done_i |-> (!head_empty_i && head_route_i == ROUTE_FPU_RED))
    else $error("FPU reduction done while not at the head");

endmodule : opbus_steer_ctrl

`default_nettype wire

//--- hdl/opbus_stream_mux.sv
////////////////////////////////////////////////////////////////////////////
// Operand-bus stream mux
// Picks operand queue, ALU or FPU onto the shared bus and steers valid
// and ready between the slide unit and the address generator
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module opbus_stream_mux (
  input  opbus_pkg::bus_sel_e bus_sel_i,
  input  opbus_pkg::route_e   head_route_i,
  input  wire logic           head_empty_i,
  input  lane_pkg::elen_t     opq_data_i,
  input  wire logic           opq_valid_i,
  output logic                opq_ready_o,
  input  lane_pkg::elen_t     alu_red_data_i,
  input  wire logic           alu_red_valid_i,
  output logic                alu_red_ready_o,
  input  lane_pkg::elen_t     fpu_red_data_i,
  input  wire logic           fpu_red_valid_i,
  output logic                fpu_red_ready_o,
  input  wire logic           sldu_ready_i,
  input  wire logic           addrgen_ready_i,
  output lane_pkg::elen_t     bus_data_o,
  output logic                sldu_valid_o,
  output logic                addrgen_valid_o,
  output logic                beat_o
);

  import opbus_pkg::*;

  // Data path follows the select alone
  always_comb begin
    unique case (bus_sel_i)
      SEL_ALU: bus_data_o = alu_red_data_i;
      SEL_FPU: bus_data_o = fpu_red_data_i;
      default: bus_data_o = opq_data_i;
    endcase
  end

  // Handshake steering, nothing moves without a head
  always_comb begin
    sldu_valid_o    = 1'b0;
    addrgen_valid_o = 1'b0;
    opq_ready_o     = 1'b0;
    alu_red_ready_o = 1'b0;
    fpu_red_ready_o = 1'b0;
    if (!head_empty_i) begin
      unique case (bus_sel_i)
        SEL_ALU: begin
          sldu_valid_o    = alu_red_valid_i;
          alu_red_ready_o = sldu_ready_i;
        end
        SEL_FPU: begin
          sldu_valid_o    = fpu_red_valid_i;
          fpu_red_ready_o = sldu_ready_i;
        end
        default: begin
          if (head_route_i == ROUTE_SLDU) begin
            sldu_valid_o = opq_valid_i;
            opq_ready_o  = sldu_ready_i;
          end else if (head_route_i == ROUTE_ADDRGEN) begin
            addrgen_valid_o = opq_valid_i;
            opq_ready_o     = addrgen_ready_i;
          end
        end
      endcase
    end
  end

  // One operand-queue element accepted
  assign beat_o = opq_valid_i & opq_ready_o;

endmodule : opbus_stream_mux

`default_nettype wire

//--- hdl/opbus_arbiter.sv
////////////////////////////////////////////////////////////////////////////
// Operand-bus arbiter
// Serializes the shared lane bus toward slide unit and address generator
// in instruction order
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module opbus_arbiter (
  input  wire logic         clk_i,
  input  wire logic         arst_n_i,
  input  wire logic         flush_i,
  // Instruction issue
  input  wire logic         issue_valid_i,
  input  lane_pkg::ara_op_e issue_op_i,
  input  lane_pkg::vlen_t   issue_len_i,
  // Operand queue stream
  input  lane_pkg::elen_t   opq_data_i,
  input  wire logic         opq_valid_i,
  output logic              opq_ready_o,
  // Reduction streams
  input  lane_pkg::elen_t   alu_red_data_i,
  input  wire logic         alu_red_valid_i,
  output logic              alu_red_ready_o,
  input  lane_pkg::elen_t   fpu_red_data_i,
  input  wire logic         fpu_red_valid_i,
  output logic              fpu_red_ready_o,
  input  wire logic         alu_red_done_i,
  input  wire logic         fpu_red_done_i,
  // Shared bus toward slide unit and address generator
  input  wire logic         sldu_ready_i,
  input  wire logic         addrgen_ready_i,
  output lane_pkg::elen_t   bus_data_o,
  output logic              sldu_valid_o,
  output logic              addrgen_valid_o
);

  import lane_pkg::*;
  import opbus_pkg::*;

  // Controller to queue
  logic     push;
  route_e   push_route;
  vlen_t    push_count;
  logic     pop;
  // Queue head
  route_e   head_route;
  vlen_t    head_count;
  logic     head_empty;
  // Stream tracking and bus control
  logic     stream_active;
  logic     stream_done;
  bus_sel_e bus_sel;
  logic     beat;

  opbus_steer_ctrl i_steer_ctrl (
    .clk_i          (clk_i         ),
    .arst_n_i       (arst_n_i      ),
    .flush_i        (flush_i       ),
    .issue_valid_i  (issue_valid_i ),
    .issue_op_i     (issue_op_i    ),
    .issue_len_i    (issue_len_i   ),
    .head_route_i   (head_route    ),
    .head_empty_i   (head_empty    ),
    .stream_done_i  (stream_done   ),
    .alu_red_done_i (alu_red_done_i),
    .fpu_red_done_i (fpu_red_done_i),
    .push_o         (push          ),
    .push_route_o   (push_route    ),
    .push_count_o   (push_count    ),
    .pop_o          (pop           ),
    .stream_active_o(stream_active ),
    .bus_sel_o      (bus_sel       )
  );

  // Full is only checked inside the queue
  opbus_order_fifo i_order_fifo (
    .clk_i   (clk_i     ),
    .arst_n_i(arst_n_i  ),
    .flush_i (flush_i   ),
    .push_i  (push      ),
    .route_i (push_route),
    .count_i (push_count),
    .pop_i   (pop       ),
    .route_o (head_route),
    .count_o (head_count),
    .empty_o (head_empty),
    .full_o  (          )
  );

  opbus_elem_counter i_elem_counter (
    .clk_i   (clk_i        ),
    .arst_n_i(arst_n_i     ),
    .flush_i (flush_i      ),
    .active_i(stream_active),
    .count_i (head_count   ),
    .beat_i  (beat         ),
    .done_o  (stream_done  )
  );

  opbus_stream_mux i_stream_mux (
    .bus_sel_i      (bus_sel        ),
    .head_route_i   (head_route     ),
    .head_empty_i   (head_empty     ),
    .opq_data_i     (opq_data_i     ),
    .opq_valid_i    (opq_valid_i    ),
    .opq_ready_o    (opq_ready_o    ),
    .alu_red_data_i (alu_red_data_i ),
    .alu_red_valid_i(alu_red_valid_i),
    .alu_red_ready_o(alu_red_ready_o),
    .fpu_red_data_i (fpu_red_data_i ),
    .fpu_red_valid_i(fpu_red_valid_i),
    .fpu_red_ready_o(fpu_red_ready_o),
    .sldu_ready_i   (sldu_ready_i   ),
    .addrgen_ready_i(addrgen_ready_i),
    .bus_data_o     (bus_data_o     ),
    .sldu_valid_o   (sldu_valid_o   ),
    .addrgen_valid_o(addrgen_valid_o),
    .beat_o         (beat           )
  );

endmodule : opbus_arbiter

`default_nettype wire

//--- tests/opbus_ref.svh
////////////////////////////////////////////////////////////////////////////
// Operand-bus reference model
// Expected route, beat count and element data of one issued instruction
////////////////////////////////////////////////////////////////////////////

`ifndef OPBUS_REF_SVH
`define OPBUS_REF_SVH

// Returns 1 for an opcode that uses the shared bus, together with its route
function automatic bit classify_op(input ara_op_e op, output route_e route);
  route = ROUTE_SLDU;
  case (op)
    VSLIDEUP, VSLIDEDOWN: begin
      route = ROUTE_SLDU;
      return 1'b1;
    end
    VLXE, VSXE: begin
      route = ROUTE_ADDRGEN;
      return 1'b1;
    end
    VREDSUM, VWREDSUM: begin
      route = ROUTE_ALU_RED;
      return 1'b1;
    end
    VFREDUSUM, VFWREDOSUM: begin
      route = ROUTE_FPU_RED;
      return 1'b1;
    end
    default: return 1'b0;
  endcase
endfunction

// A reduction puts a single result on the bus
function automatic int unsigned expected_beats(input route_e route, input int unsigned len);
  if (route == ROUTE_ALU_RED || route == ROUTE_FPU_RED) begin
    return 1;
  end
  return len;
endfunction

// Instruction number and element index in the upper half, random below
function automatic elen_t element_data(input int unsigned seq, input int unsigned idx);
  return {16'(seq), 16'(idx), $urandom()};
endfunction

`endif

//--- tests/opbus_tb.sv
////////////////////////////////////////////////////////////////////////////
// Operand-bus arbiter testbench
// Random sources and sinks around the arbiter, with a scoreboard that
// checks order, route and data of every bus transfer
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module opbus_tb;

  import lane_pkg::*;
  import opbus_pkg::*;

  `include "opbus_ref.svh"

  localparam int unsigned WaitLimit = 5000;

  logic    clk_i           = 1'b0;
  logic    arst_n_i        = 1'b0;
  logic    flush_i         = 1'b0;
  logic    issue_valid_i   = 1'b0;
  ara_op_e issue_op_i      = VADD;
  vlen_t   issue_len_i     = '0;
  elen_t   opq_data_i      = '0;
  logic    opq_valid_i     = 1'b0;
  logic    opq_ready_o;
  elen_t   alu_red_data_i  = '0;
  logic    alu_red_valid_i = 1'b0;
  logic    alu_red_ready_o;
  elen_t   fpu_red_data_i  = '0;
  logic    fpu_red_valid_i = 1'b0;
  logic    fpu_red_ready_o;
  logic    alu_red_done_i  = 1'b0;
  logic    fpu_red_done_i  = 1'b0;
  logic    sldu_ready_i    = 1'b0;
  logic    addrgen_ready_i = 1'b0;
  elen_t   bus_data_o;
  logic    sldu_valid_o;
  logic    addrgen_valid_o;

  // Scoreboard, one entry per expected bus element
  route_e sb_route [$];
  elen_t  sb_data  [$];
  bit     sb_last  [$];
  // Data waiting in the source models
  elen_t  opq_src [$];
  elen_t  alu_src [$];
  elen_t  fpu_src [$];

  int unsigned issued_cnt   = 0;
  int unsigned done_cnt     = 0;
  int unsigned insn_seq     = 0;
  int unsigned bus_errs     = 0;
  int unsigned proto_errs   = 0;
  int unsigned seq_errs     = 0;
  int unsigned timeout_errs = 0;
  bit          red_pending  = 1'b0;

  opbus_arbiter dut (.*);

  always #50 clk_i = ~clk_i;

  ////////////////////////////////////////////////////////////////////////////
  // Source and sink models
  ////////////////////////////////////////////////////////////////////////////

  always @(posedge clk_i) begin
    sldu_ready_i    <= ($urandom_range(9) < 7);
    addrgen_ready_i <= ($urandom_range(9) < 5);
  end

  // Operand queue, valid and data stay put until accepted
  always @(posedge clk_i) begin
    if (flush_i) begin
      opq_src.delete();
      opq_valid_i <= 1'b0;
    end else if (!opq_valid_i || opq_ready_o) begin
      if (opq_valid_i) begin
        void'(opq_src.pop_front());
      end
      if (opq_src.size() > 0 && $urandom_range(3) != 0) begin
        opq_valid_i <= 1'b1;
        opq_data_i  <= opq_src[0];
      end else begin
        opq_valid_i <= 1'b0;
      end
    end
  end

  // ALU reduction unit, done follows the accepted result by one cycle
  always @(posedge clk_i) begin
    alu_red_done_i <= 1'b0;
    if (flush_i) begin
      alu_src.delete();
      alu_red_valid_i <= 1'b0;
    end else if (alu_red_valid_i && alu_red_ready_o) begin
      void'(alu_src.pop_front());
      alu_red_valid_i <= 1'b0;
      alu_red_done_i  <= 1'b1;
    end else if (!alu_red_valid_i && !alu_red_done_i && alu_src.size() > 0 &&
                 $urandom_range(1) == 0) begin
      alu_red_valid_i <= 1'b1;
      alu_red_data_i  <= alu_src[0];
    end
  end

  // FPU reduction unit
  always @(posedge clk_i) begin
    fpu_red_done_i <= 1'b0;
    if (flush_i) begin
      fpu_src.delete();
      fpu_red_valid_i <= 1'b0;
    end else if (fpu_red_valid_i && fpu_red_ready_o) begin
      void'(fpu_src.pop_front());
      fpu_red_valid_i <= 1'b0;
      fpu_red_done_i  <= 1'b1;
    end else if (!fpu_red_valid_i && !fpu_red_done_i && fpu_src.size() > 0 &&
                 $urandom_range(1) == 0) begin
      fpu_red_valid_i <= 1'b1;
      fpu_red_data_i  <= fpu_src[0];
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Comparison
  ////////////////////////////////////////////////////////////////////////////

  task automatic check_beat();
    route_e got_route;
    route_e exp_route;
    elen_t  exp_data;
    bit     exp_last;
    if (addrgen_valid_o) got_route = ROUTE_ADDRGEN;
    else if (alu_red_ready_o) got_route = ROUTE_ALU_RED;
    else if (fpu_red_ready_o) got_route = ROUTE_FPU_RED;
    else got_route = ROUTE_SLDU;
    assert (sb_data.size() > 0) else begin
      $display("Bus transfer at %0t with no element left in the scoreboard", $time);
      proto_errs++;
    end
    if (sb_data.size() > 0) begin
      exp_route = sb_route.pop_front();
      exp_data  = sb_data.pop_front();
      exp_last  = sb_last.pop_front();
      assert (got_route == exp_route) else begin
        $display("[ERROR] route of bus_data_o exp 0x%h got 0x%h", exp_route, got_route);
        bus_errs++;
      end
      assert (bus_data_o == exp_data) else begin
        $display("[ERROR] bus_data_o exp 0x%h got 0x%h", exp_data, bus_data_o);
        bus_errs++;
      end
      // Reductions complete on their done pulse, streams on the last element
      if (got_route == ROUTE_ALU_RED || got_route == ROUTE_FPU_RED) red_pending = 1'b1;
      else if (exp_last) done_cnt++;
    end
  endtask

  always @(posedge clk_i) begin
    if (flush_i) begin
      sb_route.delete();
      sb_data.delete();
      sb_last.delete();
      red_pending = 1'b0;
    end else if (arst_n_i) begin
      // Nothing may move while idle or while a reduction awaits done
      if (red_pending || sb_route.size() == 0) begin
        assert (!sldu_valid_o && !addrgen_valid_o) else begin
          $display("[ERROR] sldu_valid_o/addrgen_valid_o exp 0x0/0x0 got 0x%h/0x%h",
                   sldu_valid_o, addrgen_valid_o);
          proto_errs++;
        end
      end else if (sb_route[0] == ROUTE_ADDRGEN) begin
        assert (!sldu_valid_o) else begin
          $display("[ERROR] sldu_valid_o exp 0x0 got 0x%h", sldu_valid_o);
          proto_errs++;
        end
      end else begin
        assert (!addrgen_valid_o) else begin
          $display("[ERROR] addrgen_valid_o exp 0x0 got 0x%h", addrgen_valid_o);
          proto_errs++;
        end
      end
      if (alu_red_done_i || fpu_red_done_i) begin
        done_cnt++;
        red_pending = 1'b0;
      end
      if ((sldu_valid_o && sldu_ready_i) || (addrgen_valid_o && addrgen_ready_i)) begin
        check_beat();
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////////////////////

  task automatic release_reset();
    @(posedge clk_i);
    arst_n_i <= 1'b1;
  endtask

  task automatic wait_for_slot();
    int unsigned t;
    t = 0;
    while (issued_cnt - done_cnt >= NrVInsn && t < WaitLimit) begin
      @(posedge clk_i);
      t++;
    end
    assert (issued_cnt - done_cnt < NrVInsn) else begin
      $display("Timeout while waiting for a free instruction slot");
      timeout_errs++;
    end
  endtask

  task automatic wait_drained();
    int unsigned t;
    t = 0;
    while ((issued_cnt != done_cnt || sb_data.size() != 0) && t < WaitLimit) begin
      @(posedge clk_i);
      t++;
    end
    assert (issued_cnt == done_cnt && sb_data.size() == 0) else begin
      $display("Timeout while waiting for %0d bus elements to drain", sb_data.size());
      timeout_errs++;
    end
  endtask

  // Issue pulse plus the expected traffic of the instruction
  task automatic issue_insn(input ara_op_e op, input int unsigned len);
    route_e      route;
    bit          steered;
    elen_t       word;
    int unsigned n;
    steered = classify_op(op, route);
    if (steered) wait_for_slot();
    @(posedge clk_i);
    issue_valid_i <= 1'b1;
    issue_op_i    <= op;
    issue_len_i   <= vlen_t'(len);
    if (steered) begin
      n = expected_beats(route, len);
      for (int unsigned i = 0; i < n; i++) begin
        word = element_data(insn_seq, i);
        sb_route.push_back(route);
        sb_data.push_back(word);
        sb_last.push_back(i == n - 1);
        if (route == ROUTE_ALU_RED) alu_src.push_back(word);
        else if (route == ROUTE_FPU_RED) fpu_src.push_back(word);
        else opq_src.push_back(word);
      end
      issued_cnt++;
    end
    insn_seq++;
    @(posedge clk_i);
    issue_valid_i <= 1'b0;
  endtask

  task automatic flush_pending();
    @(posedge clk_i);
    flush_i <= 1'b1;
    @(posedge clk_i);
    flush_i <= 1'b0;
    issued_cnt = done_cnt;
  endtask

  initial begin
    int unsigned seed;
    seed = $urandom(22181);
    repeat (16) @(posedge clk_i);
    assert (!sldu_valid_o && !addrgen_valid_o && !opq_ready_o &&
            !alu_red_ready_o && !fpu_red_ready_o) else begin
      $display("Valid or ready output high during reset");
      seq_errs++;
    end
    release_reset();

    // Slides, one of them at full length
    for (int i = 0; i < 6; i++) begin
      issue_insn((i % 2 == 0) ? VSLIDEUP : VSLIDEDOWN, $urandom_range(16, 1));
    end
    issue_insn(VSLIDEDOWN, MaxElems);
    wait_drained();

    // Indexed loads and stores
    for (int i = 0; i < 6; i++) begin
      issue_insn((i % 2 == 0) ? VLXE : VSXE, $urandom_range(16, 1));
    end
    wait_drained();

    // Reductions between streams
    issue_insn(VREDSUM, 8);
    issue_insn(VFREDUSUM, 8);
    issue_insn(VSLIDEUP, 5);
    issue_insn(VWREDSUM, 16);
    issue_insn(VFWREDOSUM, 4);
    issue_insn(VLXE, 3);
    wait_drained();

    // Opcodes that leave the bus alone
    issue_insn(VADD, 9);
    issue_insn(VSLIDEUP, 4);
    issue_insn(VMUL, 7);
    issue_insn(VSXE, 6);
    issue_insn(VADD, 2);
    issue_insn(VREDSUM, 3);
    wait_drained();

    // Random mix under back-pressure
    for (int i = 0; i < 80; i++) begin
      issue_insn(ara_op_e'(4'($urandom_range(9))), $urandom_range(12, 1));
    end
    wait_drained();

    // Flush with long slides still pending
    for (int i = 0; i < 4; i++) begin
      issue_insn(VSLIDEUP, 32);
    end
    flush_pending();
    // Emptied queue leaves every source without ready
    repeat (4) begin
      @(posedge clk_i);
      assert (!sldu_valid_o && !addrgen_valid_o && !opq_ready_o &&
              !alu_red_ready_o && !fpu_red_ready_o) else begin
        $display("Valid or ready output high after the flush");
        seq_errs++;
      end
    end
    issue_insn(VSLIDEDOWN, 7);
    issue_insn(VLXE, 5);
    issue_insn(VFREDUSUM, 2);
    issue_insn(VSXE, 4);
    issue_insn(VWREDSUM, 1);
    wait_drained();

    $display("Errors: bus %0d, protocol %0d, sequence %0d, timeout %0d",
             bus_errs, proto_errs, seq_errs, timeout_errs);
    if (bus_errs + proto_errs + seq_errs + timeout_errs == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule : opbus_tb

`default_nettype wire

//--- project.f
+incdir+tests
hdl/lane_pkg.sv
hdl/opbus_pkg.sv
hdl/opbus_order_fifo.sv
hdl/opbus_elem_counter.sv
hdl/opbus_steer_ctrl.sv
hdl/opbus_stream_mux.sv
hdl/opbus_arbiter.sv
tests/opbus_tb.sv

//--- run.sh
#!/bin/sh
# Compile and run the operand-bus testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module opbus_tb \
  -f project.f \
  -o opbus_sim

out="$(./obj_dir/opbus_sim)"
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx "PASS: all tests"; then
  exit 0
fi
exit 1
